// File: filelist.f
+incdir+src
src/dqn_pkg.sv
src/q_layer.sv
src/main_net.sv
src/target_net.sv
src/ann_loss_function.sv
src/ann_soft_update.sv
src/ann.sv
verification/tb_clock.sv
verification/tb_ann.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_ann \
	&& ./obj_dir/Vtb_ann | tee /dev/stderr | grep "TB PASSED" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// File: src/ann.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module ann (
	input  logic clk,
	input  logic rst_n,
	input  logic i_valid,
	input  dqn_pkg::fixed_t i_current_state_0,
	input  dqn_pkg::fixed_t i_current_state_1,
	input  dqn_pkg::fixed_t i_reward,
	input  logic [`ACTION_WIDTH-1:0] i_action,
	input  dqn_pkg::fixed_t i_next_state_0,
	input  dqn_pkg::fixed_t i_next_state_1,
	input  logic i_done,
	input  logic i_weight_valid,
	input  dqn_pkg::weight_addr_u i_weight_addr,
	input  dqn_pkg::fixed_t i_weight,
	input  logic i_load_weight_done,
	input  logic i_train_mode,
	input  logic i_update_request,
	output logic [`ACTION_WIDTH-1:0] o_action,
	output logic o_action_valid,
	output logic o_main_net_done,
	output logic o_update_done
);
	import dqn_pkg::*;

	localparam logic [1:0] MODE_LOAD = 2'd0;
	localparam logic [1:0] MODE_INTERACT = 2'd1;
	localparam logic [1:0] MODE_TRAIN = 2'd2;
	localparam logic [1:0] MODE_SYNC = 2'd3;

	logic [1:0] mode;
	logic train_active, sync_active, su_request;

	// State beats
	logic main_beat_valid, tgt_beat_valid, beat1_pending, beat_addr;
	fixed_t main_beat, tgt_beat, cur_state_1, next_state_1;

	// Weight traffic
	logic main_wr_valid, tgt_wr_valid, sync_rd_valid;
	weight_addr_u tgt_wr_addr;
	fixed_t tgt_wr_data;
	logic main_o_valid, tgt_o_valid;
	weight_addr_u tgt_o_addr;
	fixed_t main_o_weight, tgt_o_weight;
	logic su_rd_valid, su_wr_valid;
	weight_addr_u su_rd_addr, su_wr_addr;
	fixed_t su_wr_data;

	logic q_max_valid, target_valid;
	fixed_t q_max, target_value;

	assign train_active = (mode == MODE_TRAIN);
	assign sync_active = (mode == MODE_SYNC);
	assign su_request = train_active && i_update_request;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mode sequencer and beat issue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode <= MODE_LOAD;
			main_beat_valid <= 1'b0;
			tgt_beat_valid <= 1'b0;
			beat1_pending <= 1'b0;
		end else begin
			main_beat_valid <= 1'b0;
			tgt_beat_valid <= 1'b0;
			beat1_pending <= 1'b0;
			case (mode)
				MODE_LOAD: if (i_load_weight_done) mode <= MODE_INTERACT;
				MODE_INTERACT: if (i_train_mode) mode <= MODE_TRAIN;
				MODE_TRAIN: if (i_update_request) mode <= MODE_SYNC;
				default: if (o_update_done) mode <= MODE_INTERACT;
			endcase
			if (i_valid && (mode == MODE_INTERACT || train_active)) begin
				main_beat_valid <= 1'b1;
				tgt_beat_valid <= train_active;	// Next state only when training
				beat1_pending <= 1'b1;
			end else if (beat1_pending) begin
				main_beat_valid <= 1'b1;
				tgt_beat_valid <= tgt_beat_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			beat_addr <= 1'b0;
			main_beat <= i_current_state_0;
			tgt_beat <= i_next_state_0;
			cur_state_1 <= i_current_state_1;
			next_state_1 <= i_next_state_1;
		end else if (beat1_pending) begin
			beat_addr <= 1'b1;
			main_beat <= cur_state_1;
			tgt_beat <= next_state_1;
		end
	end

	// Loads go to both nets, blended weights to the target only
	assign main_wr_valid = (mode == MODE_LOAD) && i_weight_valid;
	assign tgt_wr_valid = (mode == MODE_LOAD) ? i_weight_valid : (sync_active && su_wr_valid);
	assign tgt_wr_addr = sync_active ? su_wr_addr : i_weight_addr;
	assign tgt_wr_data = sync_active ? su_wr_data : i_weight;
	assign sync_rd_valid = sync_active && su_rd_valid;

	main_net u_main_net (
		.clk(clk), .rst_n(rst_n),
		.i_data_valid(main_beat_valid), .i_data_addr(beat_addr), .i_data(main_beat),
		.i_weight_valid(main_wr_valid), .i_weight_addr(i_weight_addr), .i_weight(i_weight),
		.i_read_valid(sync_rd_valid), .i_read_addr(su_rd_addr),
		.i_train_action_valid(i_valid), .i_train_action(i_action),
		.i_train_mode(train_active),
		.i_target_value_valid(target_valid), .i_target_value(target_value),
		.o_weight_valid(main_o_valid), .o_weight_addr(), .o_weight(main_o_weight),
		.o_arg_max_valid(o_action_valid), .o_arg_max(o_action),
		.o_main_net_done(o_main_net_done)
	);

	target_net u_target_net (
		.clk(clk), .rst_n(rst_n),
		.i_data_valid(tgt_beat_valid), .i_data_addr(beat_addr), .i_data(tgt_beat),
		.i_weight_valid(tgt_wr_valid), .i_weight_addr(tgt_wr_addr), .i_weight(tgt_wr_data),
		.i_read_valid(sync_rd_valid), .i_read_addr(su_rd_addr),
		.o_weight_valid(tgt_o_valid), .o_weight_addr(tgt_o_addr), .o_weight(tgt_o_weight),
		.o_q_max_valid(q_max_valid), .o_q_max(q_max)
	);

	ann_loss_function u_loss (
		.clk(clk), .rst_n(rst_n),
		.i_reward_valid(i_valid), .i_reward(i_reward), .i_done(i_done),
		.i_q_max_valid(q_max_valid), .i_q_max(q_max),
		.o_target_value_valid(target_valid), .o_target_value(target_value)
	);

	ann_soft_update u_soft_update (
		.clk(clk), .rst_n(rst_n),
		.i_update_request(su_request),
		.i_main_weight_valid(main_o_valid), .i_main_weight(main_o_weight),
		.i_target_weight_valid(tgt_o_valid), .i_target_weight(tgt_o_weight),
		.i_target_weight_addr(tgt_o_addr),
		.o_read_valid(su_rd_valid), .o_read_addr(su_rd_addr),
		.o_update_weight_valid(su_wr_valid), .o_update_weight_addr(su_wr_addr),
		.o_update_weight(su_wr_data),
		.o_update_done(o_update_done)
	);

	// One step must drain before the next
	a_valid_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |=> !i_valid [*11]);

endmodule

// File: src/ann_loss_function.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module ann_loss_function (
	input  logic clk,
	input  logic rst_n,
	input  logic i_reward_valid,
	input  dqn_pkg::fixed_t i_reward,
	input  logic i_done,
	input  logic i_q_max_valid,
	input  dqn_pkg::fixed_t i_q_max,
	output logic o_target_value_valid,
	output dqn_pkg::fixed_t o_target_value
);
	import dqn_pkg::*;

	fixed_t reward_reg;
	logic done_reg;
	fixed_t discounted;

	assign discounted = i_q_max - (i_q_max >>> `GAMMA_SHIFT);	// Gamma * q max

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_target_value_valid <= 1'b0;
		else
			o_target_value_valid <= i_q_max_valid;
	end

	always_ff @(posedge clk) begin
		if (i_reward_valid) begin
			reward_reg <= i_reward;
			done_reg <= i_done;
		end
		if (i_q_max_valid)
			o_target_value <= done_reg ? reward_reg : reward_reg + discounted;	// Terminal
	end

endmodule

// File: src/ann_soft_update.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module ann_soft_update (
	input  logic clk,
	input  logic rst_n,
	input  logic i_update_request,
	input  logic i_main_weight_valid,
	input  dqn_pkg::fixed_t i_main_weight,
	input  logic i_target_weight_valid,
	input  dqn_pkg::fixed_t i_target_weight,
	input  dqn_pkg::weight_addr_u i_target_weight_addr,
	output logic o_read_valid,
	output dqn_pkg::weight_addr_u o_read_addr,
	output logic o_update_weight_valid,
	output dqn_pkg::weight_addr_u o_update_weight_addr,
	output dqn_pkg::fixed_t o_update_weight,
	output logic o_update_done
);
	import dqn_pkg::*;

	localparam logic [`WADDR_WIDTH-1:0] LAST_IDX =
		`WADDR_WIDTH'(`NUM_ACTIONS * `NUM_INPUTS - 1);

	logic busy;
	logic rd_pending;	// Read data due this cycle
	fixed_t blended;

	assign blended = i_target_weight + ((i_main_weight - i_target_weight) >>> `TAU_SHIFT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rd_pending <= 1'b0;
			o_read_valid <= 1'b0;
			o_read_addr <= '0;
			o_update_weight_valid <= 1'b0;
			o_update_done <= 1'b0;
		end else begin
			o_read_valid <= 1'b0;
			o_update_weight_valid <= 1'b0;
			o_update_done <= 1'b0;
			rd_pending <= o_read_valid;
			if (i_update_request && !busy) begin
				busy <= 1'b1;
				o_read_valid <= 1'b1;
				o_read_addr.idx <= '0;
			end else if (rd_pending) begin
				o_update_weight_valid <= 1'b1;
				if (i_target_weight_addr.idx == LAST_IDX) begin
					busy <= 1'b0;
					o_update_done <= 1'b1;	// With the last write
				end else begin
					o_read_valid <= 1'b1;
					o_read_addr.idx <= i_target_weight_addr.idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_pending) begin
			o_update_weight_addr <= i_target_weight_addr;
			o_update_weight <= blended;
		end
	end

	a_reads_paired: assert property (@(posedge clk) disable iff (!rst_n)
		rd_pending |-> (i_main_weight_valid && i_target_weight_valid));

endmodule

// File: src/dqn_config.svh
`ifndef DQN_CONFIG_SVH
`define DQN_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point format
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DATA_WIDTH		16	// Q8.8 word
`define FRAC_BITS		8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Network shape
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_INPUTS		2
`define NUM_ACTIONS		3
`define ACTION_WIDTH	2
`define WADDR_WIDTH		3	// Six weights used

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rates as power-of-two shifts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LR_SHIFT		4	// Learning rate 1/16
`define GAMMA_SHIFT		2	// Gamma 0.75
`define TAU_SHIFT		1	// Update rate 0.5

`endif

// File: src/dqn_pkg.sv
`include "dqn_config.svh"

package dqn_pkg;

	// Signed Q8.8 word
	typedef logic signed [`DATA_WIDTH-1:0] fixed_t;

	// Weight address = action * 2 + input, so both views name the same word
	typedef union packed {
		logic [`WADDR_WIDTH-1:0] idx;	// Flat walk order
		struct packed {
			logic [`ACTION_WIDTH-1:0] row;	// Action
			logic col;	// State input
		} rc;
	} weight_addr_u;

endpackage

// File: src/main_net.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module main_net (
	input  logic clk,
	input  logic rst_n,
	input  logic i_data_valid,
	input  logic i_data_addr,
	input  dqn_pkg::fixed_t i_data,
	input  logic i_weight_valid,
	input  dqn_pkg::weight_addr_u i_weight_addr,
	input  dqn_pkg::fixed_t i_weight,
	input  logic i_read_valid,
	input  dqn_pkg::weight_addr_u i_read_addr,
	input  logic i_train_action_valid,
	input  logic [`ACTION_WIDTH-1:0] i_train_action,
	input  logic i_train_mode,
	input  logic i_target_value_valid,
	input  dqn_pkg::fixed_t i_target_value,
	output logic o_weight_valid,
	output dqn_pkg::weight_addr_u o_weight_addr,
	output dqn_pkg::fixed_t o_weight,
	output logic o_arg_max_valid,
	output logic [`ACTION_WIDTH-1:0] o_arg_max,
	output logic o_main_net_done
);
	import dqn_pkg::*;

	localparam int PROD_WIDTH = 2 * `DATA_WIDTH;

	logic layer_wr_valid, layer_rd_valid, layer_o_valid, q_valid;
	weight_addr_u layer_wr_addr, layer_rd_addr;
	weight_addr_u int_wr_addr, int_rd_addr;
	fixed_t layer_wr_data;
	fixed_t q_0, q_1, q_2;
	fixed_t state [`NUM_INPUTS];
	fixed_t best_q, sel_q, taken_q, td_error, delta;
	logic [`ACTION_WIDTH-1:0] best_action, taken_action;
	logic [1:0] upd_phase;	// 0 idle, 1 writes col 0, 2 writes col 1
	logic int_rd, int_rd_q, int_wr;
	logic signed [PROD_WIDTH-1:0] err_prod;

	q_layer u_layer (
		.clk(clk), .rst_n(rst_n),
		.i_data_valid(i_data_valid), .i_data_addr(i_data_addr), .i_data(i_data),
		.i_weight_valid(layer_wr_valid), .i_weight_addr(layer_wr_addr),
		.i_weight(layer_wr_data),
		.i_read_valid(layer_rd_valid), .i_read_addr(layer_rd_addr),
		.o_weight_valid(layer_o_valid), .o_weight_addr(o_weight_addr), .o_weight(o_weight),
		.o_q_valid(q_valid), .o_q_0(q_0), .o_q_1(q_1), .o_q_2(q_2)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Action selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		best_action = '0;
		best_q = q_0;
		if (q_1 > best_q) begin
			best_action = 2'd1;
			best_q = q_1;
		end
		if (q_2 > best_q) begin
			best_action = 2'd2;
			best_q = q_2;
		end
		case (taken_action)
			2'd1: sel_q = q_1;
			2'd2: sel_q = q_2;
			default: sel_q = q_0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Row update: read old weight, write it back one cycle later
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign int_rd = (i_target_value_valid && i_train_mode) || (upd_phase == 2'd1);
	assign int_wr = (upd_phase != 2'd0);

	always_comb begin
		int_rd_addr.rc.row = taken_action;
		int_rd_addr.rc.col = (upd_phase == 2'd1);
		int_wr_addr.rc.row = taken_action;
		int_wr_addr.rc.col = (upd_phase == 2'd2);
	end

	assign err_prod = td_error * state[int_wr_addr.rc.col];
	assign delta = fixed_t'((err_prod >>> `FRAC_BITS) >>> `LR_SHIFT);

	assign layer_wr_valid = int_wr || i_weight_valid;	// Training write wins
	assign layer_wr_addr = int_wr ? int_wr_addr : i_weight_addr;
	assign layer_wr_data = int_wr ? o_weight + delta : i_weight;
	assign layer_rd_valid = int_rd || i_read_valid;
	assign layer_rd_addr = int_rd ? int_rd_addr : i_read_addr;
	assign o_weight_valid = layer_o_valid && !int_rd_q;	// Hide own reads

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_arg_max_valid <= 1'b0;
			o_main_net_done <= 1'b0;
			upd_phase <= 2'd0;
			int_rd_q <= 1'b0;
		end else begin
			o_arg_max_valid <= q_valid;
			o_main_net_done <= q_valid && !i_train_mode;
			int_rd_q <= int_rd;
			case (upd_phase)
				2'd0: if (i_target_value_valid && i_train_mode) upd_phase <= 2'd1;
				2'd1: upd_phase <= 2'd2;
				default: begin
					upd_phase <= 2'd0;
					o_main_net_done <= 1'b1;	// Second weight written
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_data_valid)
			state[i_data_addr] <= i_data;
		if (i_train_action_valid)
			taken_action <= i_train_action;
		if (q_valid) begin
			o_arg_max <= best_action;
			taken_q <= sel_q;
		end
		if (i_target_value_valid)
			td_error <= i_target_value - taken_q;
	end

endmodule

// File: src/q_layer.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module q_layer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_data_valid,
	input  logic i_data_addr,
	input  dqn_pkg::fixed_t i_data,
	input  logic i_weight_valid,
	input  dqn_pkg::weight_addr_u i_weight_addr,
	input  dqn_pkg::fixed_t i_weight,
	input  logic i_read_valid,
	input  dqn_pkg::weight_addr_u i_read_addr,
	output logic o_weight_valid,
	output dqn_pkg::weight_addr_u o_weight_addr,
	output dqn_pkg::fixed_t o_weight,
	output logic o_q_valid,
	output dqn_pkg::fixed_t o_q_0,
	output dqn_pkg::fixed_t o_q_1,
	output dqn_pkg::fixed_t o_q_2
);
	import dqn_pkg::*;

	localparam int NUM_WEIGHTS = `NUM_ACTIONS * `NUM_INPUTS;
	localparam int PROD_WIDTH = 2 * `DATA_WIDTH;
	localparam logic [`ACTION_WIDTH-1:0] LAST_ROW = `ACTION_WIDTH'(`NUM_ACTIONS - 1);

	fixed_t weights [NUM_WEIGHTS];
	fixed_t state [`NUM_INPUTS];
	fixed_t q_reg [`NUM_ACTIONS];

	logic running;
	logic [`ACTION_WIDTH-1:0] row;	// Row in work, LAST_ROW+1 is the valid cycle
	weight_addr_u addr_a;
	weight_addr_u addr_b;
	logic signed [PROD_WIDTH-1:0] prod_a;
	logic signed [PROD_WIDTH-1:0] prod_b;

	always_comb begin
		addr_a.rc.row = row;
		addr_a.rc.col = 1'b0;
		addr_b = addr_a;
		addr_b.rc.col = 1'b1;
	end

	assign prod_a = weights[addr_a.idx] * state[0];
	assign prod_b = weights[addr_b.idx] * state[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			row <= '0;
			o_q_valid <= 1'b0;
			o_weight_valid <= 1'b0;
		end else begin
			o_q_valid <= 1'b0;
			o_weight_valid <= i_read_valid;
			if (i_data_valid && i_data_addr) begin
				running <= 1'b1;	// Both inputs held
				row <= '0;
			end else if (running) begin
				if (row == LAST_ROW + 1'b1) begin
					running <= 1'b0;
					o_q_valid <= 1'b1;
				end else begin
					row <= row + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_data_valid)
			state[i_data_addr] <= i_data;
		if (running && row <= LAST_ROW)
			q_reg[row] <= fixed_t'(prod_a >>> `FRAC_BITS) + fixed_t'(prod_b >>> `FRAC_BITS);
		if (i_weight_valid)
			weights[i_weight_addr.idx] <= i_weight;
		o_weight_addr <= i_read_addr;
		o_weight <= weights[i_read_addr.idx];	// One cycle read latency
	end

	assign o_q_0 = q_reg[0];
	assign o_q_1 = q_reg[1];
	assign o_q_2 = q_reg[2];

	a_beat_order: assert property (@(posedge clk) disable iff (!rst_n)
		(i_data_valid && i_data_addr) |-> $past(i_data_valid && !i_data_addr));

endmodule

// File: src/target_net.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module target_net (
	input  logic clk,
	input  logic rst_n,
	input  logic i_data_valid,
	input  logic i_data_addr,
	input  dqn_pkg::fixed_t i_data,
	input  logic i_weight_valid,
	input  dqn_pkg::weight_addr_u i_weight_addr,
	input  dqn_pkg::fixed_t i_weight,
	input  logic i_read_valid,
	input  dqn_pkg::weight_addr_u i_read_addr,
	output logic o_weight_valid,
	output dqn_pkg::weight_addr_u o_weight_addr,
	output dqn_pkg::fixed_t o_weight,
	output logic o_q_max_valid,
	output dqn_pkg::fixed_t o_q_max
);
	import dqn_pkg::*;

	logic q_valid;
	fixed_t q_0, q_1, q_2;
	fixed_t q_max;

	q_layer u_layer (
		.clk(clk), .rst_n(rst_n),
		.i_data_valid(i_data_valid), .i_data_addr(i_data_addr), .i_data(i_data),
		.i_weight_valid(i_weight_valid), .i_weight_addr(i_weight_addr), .i_weight(i_weight),
		.i_read_valid(i_read_valid), .i_read_addr(i_read_addr),
		.o_weight_valid(o_weight_valid), .o_weight_addr(o_weight_addr), .o_weight(o_weight),
		.o_q_valid(q_valid), .o_q_0(q_0), .o_q_1(q_1), .o_q_2(q_2)
	);

	always_comb begin
		q_max = q_0;
		if (q_1 > q_max) q_max = q_1;
		if (q_2 > q_max) q_max = q_2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_q_max_valid <= 1'b0;
		else
			o_q_max_valid <= q_valid;
	end

	always_ff @(posedge clk) begin
		if (q_valid)
			o_q_max <= q_max;
	end

endmodule

// File: verification/tb_ann.sv
`timescale 1ns/1ns
`include "dqn_config.svh"

module tb_ann;
	import dqn_pkg::*;

	localparam int DRIVE_DELAY = 10;
	localparam int NUM_WEIGHTS = `NUM_ACTIONS * `NUM_INPUTS;
	localparam int ACTION_EDGE = 7;	// Edges after the i_valid edge
	localparam int TRAIN_DONE_EDGE = 11;
	localparam int SYNC_DONE_EDGE = 12;
	localparam int WEIGHT_SPAN = 256;	// +-1.0
	localparam int STATE_SPAN = 512;
	localparam int REWARD_SPAN = 512;
	localparam int N_INFER = 8;
	localparam int N_TRAIN = 8;
	localparam int N_TERM = 6;
	localparam int N_POST = 6;
	localparam int NUM_STEPS = 2 * N_INFER + N_TRAIN + N_TERM + N_POST + 2;
	localparam int LOAD_CYCLES = 10 + NUM_WEIGHTS + 8;
	localparam int WATCHDOG_CYCLES = NUM_STEPS * 40 + LOAD_CYCLES;

	logic clk, rst_n;
	logic i_valid, i_done, i_weight_valid, i_load_weight_done;
	logic i_train_mode, i_update_request;
	fixed_t i_current_state_0, i_current_state_1, i_reward;
	fixed_t i_next_state_0, i_next_state_1, i_weight;
	logic [`ACTION_WIDTH-1:0] i_action, o_action;
	weight_addr_u i_weight_addr;
	logic o_action_valid, o_main_net_done, o_update_done;

	fixed_t main_w [NUM_WEIGHTS];	// Reference weights
	fixed_t tgt_w [NUM_WEIGHTS];
	logic [31:0] rng;
	logic [`ACTION_WIDTH-1:0] exp_action;
	logic started, step_infer, step_train, sync_req;
	logic [15:0] infer_hist = '0;
	logic [15:0] train_hist = '0;
	logic [15:0] sync_hist = '0;
	logic exp_action_valid, exp_done, exp_update_done;
	int fail_count, fails_at_test_start, test_num, tests_passed, tests_failed;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	ann dut (
		.clk(clk), .rst_n(rst_n),
		.i_valid(i_valid), .i_current_state_0(i_current_state_0),
		.i_current_state_1(i_current_state_1), .i_reward(i_reward), .i_action(i_action),
		.i_next_state_0(i_next_state_0), .i_next_state_1(i_next_state_1), .i_done(i_done),
		.i_weight_valid(i_weight_valid), .i_weight_addr(i_weight_addr), .i_weight(i_weight),
		.i_load_weight_done(i_load_weight_done), .i_train_mode(i_train_mode),
		.i_update_request(i_update_request),
		.o_action(o_action), .o_action_valid(o_action_valid),
		.o_main_net_done(o_main_net_done), .o_update_done(o_update_done)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expected strobe timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		infer_hist <= {infer_hist[14:0], step_infer};	// Bit n set n edges after i_valid
		train_hist <= {train_hist[14:0], step_train};
		sync_hist <= {sync_hist[14:0], sync_req};
	end

	assign exp_action_valid = infer_hist[ACTION_EDGE] || train_hist[ACTION_EDGE];
	assign exp_done = infer_hist[ACTION_EDGE] || train_hist[TRAIN_DONE_EDGE];
	assign exp_update_done = sync_hist[SYNC_DONE_EDGE];

	task automatic report_mismatch(input string sig, input int got, input int expected);
		$display("** Error at %0t ns: %s = %0d, expected %0d", $time, sig, got, expected);
		fail_count++;
	endtask

	task automatic note_failure(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		fail_count++;
	endtask

	a_reset_quiet: assert property (@(posedge clk)
		!started |-> !(o_action_valid || o_main_net_done || o_update_done))
		else note_failure("an output strobe went high before the first step");

	a_action_timing: assert property (@(posedge clk) disable iff (!rst_n)
		o_action_valid == exp_action_valid)
		else report_mismatch("o_action_valid", $sampled(o_action_valid),
			$sampled(exp_action_valid));

	a_done_timing: assert property (@(posedge clk) disable iff (!rst_n)
		o_main_net_done == exp_done)
		else report_mismatch("o_main_net_done", $sampled(o_main_net_done), $sampled(exp_done));

	a_action_value: assert property (@(posedge clk) disable iff (!rst_n)
		o_action_valid |-> (o_action == exp_action))
		else report_mismatch("o_action", $sampled(o_action), $sampled(exp_action));

	a_update_timing: assert property (@(posedge clk) disable iff (!rst_n)
		o_update_done == exp_update_done)
		else report_mismatch("o_update_done", $sampled(o_update_done),
			$sampled(exp_update_done));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_word();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic fixed_t rand_fixed(input int span);
		int v;
		v = int'(next_word() % 32'(2 * span)) - span;
		return fixed_t'(v);
	endfunction

	function automatic fixed_t scale(input fixed_t a, input fixed_t b);
		logic signed [2*`DATA_WIDTH-1:0] p;
		p = a * b;
		return fixed_t'(p >>> `FRAC_BITS);
	endfunction

	// Weight of action row r and input c sits at r * 2 + c
	function automatic fixed_t q_of(input logic use_tgt, input int row,
		input fixed_t s0, input fixed_t s1);
		fixed_t w0, w1;
		w0 = use_tgt ? tgt_w[row * `NUM_INPUTS] : main_w[row * `NUM_INPUTS];
		w1 = use_tgt ? tgt_w[row * `NUM_INPUTS + 1] : main_w[row * `NUM_INPUTS + 1];
		return scale(w0, s0) + scale(w1, s1);
	endfunction

	function automatic logic [`ACTION_WIDTH-1:0] best_action(input fixed_t s0, input fixed_t s1);
		logic [`ACTION_WIDTH-1:0] best;
		fixed_t best_q;
		best = '0;
		best_q = q_of(1'b0, 0, s0, s1);
		for (int r = 1; r < `NUM_ACTIONS; r++) begin
			if (q_of(1'b0, r, s0, s1) > best_q) begin	// Ties keep the lower index
				best = `ACTION_WIDTH'(r);
				best_q = q_of(1'b0, r, s0, s1);
			end
		end
		return best;
	endfunction

	function automatic fixed_t target_max(input fixed_t s0, input fixed_t s1);
		fixed_t m;
		m = q_of(1'b1, 0, s0, s1);
		for (int r = 1; r < `NUM_ACTIONS; r++)
			if (q_of(1'b1, r, s0, s1) > m)
				m = q_of(1'b1, r, s0, s1);
		return m;
	endfunction

	task automatic train_model(input fixed_t s0, input fixed_t s1, input int act,
		input fixed_t r, input fixed_t ns0, input fixed_t ns1, input logic term);
		fixed_t qm, tv, err;
		logic signed [2*`DATA_WIDTH-1:0] p;
		int base;
		qm = target_max(ns0, ns1);
		tv = term ? r : r + (qm - (qm >>> `GAMMA_SHIFT));	// Gamma 0.75
		err = tv - q_of(1'b0, act, s0, s1);
		base = act * `NUM_INPUTS;
		p = err * s0;
		main_w[base] = main_w[base] + fixed_t'((p >>> `FRAC_BITS) >>> `LR_SHIFT);
		p = err * s1;
		main_w[base + 1] = main_w[base + 1] + fixed_t'((p >>> `FRAC_BITS) >>> `LR_SHIFT);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic wait_strobe(input logic for_update, input int limit, input string what);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < limit && !seen; n++) begin
			@(negedge clk);
			seen = for_update ? o_update_done : o_main_net_done;
		end
		if (!seen)
			note_failure($sformatf("%s did not finish within %0d cycles", what, limit));
	endtask

	task automatic load_weights();
		for (int i = 0; i < NUM_WEIGHTS; i++) begin
			tick();
			main_w[i] = rand_fixed(WEIGHT_SPAN);
			tgt_w[i] = main_w[i];
			i_weight_valid = 1'b1;
			i_weight_addr.idx = `WADDR_WIDTH'(i);
			i_weight = main_w[i];
		end
		tick();
		i_weight_valid = 1'b0;
		i_load_weight_done = 1'b1;
		tick();
		i_load_weight_done = 1'b0;
	endtask

	task automatic run_step(input logic train, input logic term, input logic zero_state);
		fixed_t s0, s1, ns0, ns1, r;
		logic [`ACTION_WIDTH-1:0] act;
		s0 = rand_fixed(STATE_SPAN);
		s1 = rand_fixed(STATE_SPAN);
		ns0 = rand_fixed(STATE_SPAN);
		ns1 = rand_fixed(STATE_SPAN);
		r = rand_fixed(REWARD_SPAN);
		act = `ACTION_WIDTH'(next_word() % `NUM_ACTIONS);
		if (zero_state) begin
			s0 = '0;	// All Q equal, lowest index wins
			s1 = '0;
		end
		tick();
		exp_action = best_action(s0, s1);	// Before this step's update
		if (train)
			train_model(s0, s1, int'(act), r, ns0, ns1, term);
		i_valid = 1'b1;
		i_current_state_0 = s0;
		i_current_state_1 = s1;
		i_next_state_0 = ns0;
		i_next_state_1 = ns1;
		i_reward = r;
		i_action = act;
		i_done = term;
		started = 1'b1;
		step_infer = !train;
		step_train = train;
		tick();
		i_valid = 1'b0;
		step_infer = 1'b0;
		step_train = 1'b0;
		wait_strobe(1'b0, 20, train ? "training step" : "inference step");
		repeat (4) tick();
	endtask

	task automatic run_sync();
		fixed_t diff;
		tick();
		for (int i = 0; i < NUM_WEIGHTS; i++) begin
			diff = main_w[i] - tgt_w[i];
			tgt_w[i] = tgt_w[i] + (diff >>> `TAU_SHIFT);
		end
		i_update_request = 1'b1;
		sync_req = 1'b1;
		tick();
		i_update_request = 1'b0;
		sync_req = 1'b0;
		wait_strobe(1'b1, 20, "soft update");
		repeat (4) tick();
	endtask

	task automatic enter_train();
		tick();
		i_train_mode = 1'b1;
		tick();
		i_train_mode = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = fail_count - fails_at_test_start;
		test_num++;
		if (errs == 0) begin
			tests_passed++;
			$display("test %0d %s: ok", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d failures", test_num, name, errs);
		end
		fails_at_test_start = fail_count;
	endtask

	initial begin
		i_valid = 1'b0;
		i_current_state_0 = '0;
		i_current_state_1 = '0;
		i_reward = '0;
		i_action = '0;
		i_next_state_0 = '0;
		i_next_state_1 = '0;
		i_done = 1'b0;
		i_weight_valid = 1'b0;
		i_weight_addr = '0;
		i_weight = '0;
		i_load_weight_done = 1'b0;
		i_train_mode = 1'b0;
		i_update_request = 1'b0;
		exp_action = '0;
		started = 1'b0;
		step_infer = 1'b0;
		step_train = 1'b0;
		sync_req = 1'b0;
		rng = 32'hb94c;
		fail_count = 0;
		fails_at_test_start = 0;
		test_num = 0;
		tests_passed = 0;
		tests_failed = 0;

		wait (rst_n === 1'b1);
		load_weights();
		repeat (4) tick();
		finish_test("reset state");

		for (int i = 0; i < N_INFER; i++)
			run_step(1'b0, 1'b0, i == 0);
		finish_test("inference");

		enter_train();
		for (int i = 0; i < N_TRAIN; i++)
			run_step(1'b1, 1'b0, 1'b0);
		finish_test("training");

		for (int i = 0; i < N_TERM; i++)
			run_step(1'b1, (i % 2) == 0, 1'b0);	// Every other step terminal
		finish_test("terminal steps");

		run_sync();
		enter_train();
		for (int i = 0; i < N_POST; i++)
			run_step(1'b1, 1'b0, 1'b0);
		run_sync();
		finish_test("soft update");

		for (int i = 0; i < N_INFER; i++)
			run_step(1'b0, 1'b0, i == 0);
		finish_test("return to interactive");

		$display("%0d tests, %0d passed, %0d failed, %0d check failures",
			test_num, tests_passed, tests_failed, fail_count);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles and the run did not finish",
			WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(PERIOD / 4) rst_n = 1'b1;	// Release between edges
	end

endmodule
